// ==== common/extract_defs.svh ====
// Instruction extract stage sizing
// Widths and field positions shared by the extract stage packages and RTL

`ifndef EXTRACT_DEFS_SVH
`define EXTRACT_DEFS_SVH

// Width of one instruction word
`define EXT_INS_W 32

// Width of the opcode field at the bottom of the instruction word
`define EXT_OPC_W 7

// Number of registers covered by a push or pop multiple list
`define EXT_NREGS 16

// Width of a register index within the list
`define EXT_REG_W 4

// Lowest bit of the register list mask inside the instruction word
`define EXT_MASK_LSB 16

// Lowest bit of the interrupt vector inside an injected instruction
`define EXT_VEC_LSB 8

`endif

// ==== common/ins_pkg.sv ====
// Instruction format package
// Opcodes, exception codes and the entry passed from extract to decode

package ins_pkg;

`include "extract_defs.svh"

	// ======================================================================
	// Opcodes
	// ======================================================================

	// The opcode sits in the low bits of every instruction word
	// PUSHM and POPM carry a register mask and are expanded into PUSH and POP
	typedef enum logic [`EXT_OPC_W-1:0]
	{
		OP_NOP   = 7'h00,
		OP_ALU   = 7'h01,
		OP_PUSHM = 7'h10,
		OP_POPM  = 7'h11,
		OP_PUSH  = 7'h12,
		OP_POP   = 7'h13,
		OP_IRQ   = 7'h7f
	} opcode_e;

	// ======================================================================
	// Exception codes
	// ======================================================================

	typedef enum logic [3:0]
	{
		FLT_NONE = 4'h0,
		FLT_IRQ  = 4'h1
	} fault_e;

	// ======================================================================
	// Extract entry
	// ======================================================================

	// One slot of the extract output
	// Micro-ops keep the pc of the list instruction they came from
	typedef struct packed
	{
		logic                  valid;
		fault_e                exc;
		logic [31:0]           pc;
		logic [`EXT_INS_W-1:0] ins;
		logic [`EXT_REG_W-1:0] uop_reg;
		logic                  micro;
	} entry_t;

endpackage

// ==== common/ctl_pkg.sv ====
// Extract control package
// Sequencer states and the APB register map of the stage

package ctl_pkg;

	// Sequencer states
	// IDLE takes fetched instructions, IRQ waits to inject, LIST expands a mask
	typedef enum logic [1:0]
	{
		SEQ_IDLE = 2'd0,
		SEQ_IRQ  = 2'd1,
		SEQ_LIST = 2'd2
	} seq_state_e;

	// ======================================================================
	// APB register map
	// ======================================================================

	// Control register, bit 0 enables interrupts
	localparam logic [3:0] REG_CTRL    = 4'h0;
	// Interrupt vector, 8 bits
	localparam logic [3:0] REG_VECTOR  = 4'h4;
	// Injected interrupt count, read only
	localparam logic [3:0] REG_IRQ_CNT = 4'h8;
	// Emitted micro-op count, read only
	localparam logic [3:0] REG_UOP_CNT = 4'hc;

	// Position of the interrupt enable in the control register
	localparam int CTRL_IEN_BIT = 0;

endpackage

// ==== design/extract_mux.sv ====
// Extract output register
// Picks the fetched or the injected entry and registers it for decode
// A squash turns the entry into an invalid no-op at the same pc

`timescale 1ns/1ps

module extract_mux
(
	input  logic            clk,
	input  logic            reset,
	input  logic            en,
	input  logic            nop,
	input  logic            sel_inj,
	input  ins_pkg::entry_t inj_entry,
	input  ins_pkg::entry_t fetch_entry,
	output ins_pkg::entry_t ins
);

	import ins_pkg::*;

	entry_t pick;
	entry_t nxt;
	logic   valid_q;
	entry_t payload_q;

	// Source select between the sequencer and the fetch side
	always_comb
	begin
		pick = sel_inj ? inj_entry : fetch_entry;
		nxt = pick;
		// A squashed slot keeps pc and word so decode still sees a sane nop
		if (nop)
		begin
			nxt.valid = 1'b0;
			nxt.exc = FLT_NONE;
		end
	end

	// Only the valid flag is control state
	always_ff @(posedge clk)
	begin
		if (reset)
			valid_q <= 1'b0;
		else if (en)
			valid_q <= nxt.valid;
	end

	// The rest of the slot only matters while valid is set
	always_ff @(posedge clk)
	begin
		if (en)
			payload_q <= nxt;
	end

	always_comb
	begin
		ins = payload_q;
		ins.valid = valid_q;
	end

endmodule

// ==== design/reglist_counter.sv ====
// Register list counter
// Holds the registers still to be expanded from a push or pop multiple
// and presents the lowest one, clearing it on each step

`timescale 1ns/1ps

`include "extract_defs.svh"

module reglist_counter
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  load,
	input  logic                  step,
	input  logic [`EXT_NREGS-1:0] mask,
	output logic [`EXT_REG_W-1:0] cur_reg,
	output logic                  last,
	output logic                  empty
);

	logic [`EXT_NREGS-1:0] rem;
	logic [`EXT_NREGS-1:0] rem_low_clr;

	// Clearing the lowest set bit is the usual x & (x - 1)
	assign rem_low_clr = rem & (rem - 1'b1);

	always_ff @(posedge clk)
	begin
		if (reset)
			rem <= '0;
		// A new list replaces whatever was left over
		else if (load)
			rem <= mask;
		else if (step)
			rem <= rem_low_clr;
	end

	// Priority encoder for the lowest set bit
	// Scanning from the top lets the lowest hit win
	always_comb
	begin
		cur_reg = '0;
		for (int i = `EXT_NREGS - 1; i >= 0; i--)
		begin
			if (rem[i])
				cur_reg = `EXT_REG_W'(i);
		end
	end

	assign empty = (rem == '0);

	// Exactly one bit left when removing the lowest leaves nothing
	assign last = ~empty & (rem_low_clr == '0);

endmodule

// ==== design/extract_csr.sv ====
// Extract stage register block
// APB slave with interrupt enable, interrupt vector and two event counters

`timescale 1ns/1ps

module extract_csr
(
	input  logic        clk,
	input  logic        reset,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [3:0]  paddr,
	input  logic [31:0] pwdata,
	input  logic        irq_taken,
	input  logic        uop_fire,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr,
	output logic        irq_enable,
	output logic [7:0]  irq_vector
);

	import ctl_pkg::*;

	logic        access;
	logic        wr;
	logic        mapped;
	logic [31:0] irq_cnt;
	logic [31:0] uop_cnt;

	// ======================================================================
	// Bus decode
	// ======================================================================

	// Zero wait states so the access phase always completes
	assign pready = 1'b1;
	assign access = psel & penable;
	assign wr = access & pwrite;

	assign mapped = (paddr == REG_CTRL) | (paddr == REG_VECTOR) |
		(paddr == REG_IRQ_CNT) | (paddr == REG_UOP_CNT);

	assign pslverr = access & ~mapped;

	// ======================================================================
	// Registers
	// ======================================================================

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			irq_enable <= 1'b0;
			irq_vector <= 8'h00;
			irq_cnt <= '0;
			uop_cnt <= '0;
		end
		else
		begin
			if (wr && paddr == REG_CTRL)
				irq_enable <= pwdata[CTRL_IEN_BIT];
			if (wr && paddr == REG_VECTOR)
				irq_vector <= pwdata[7:0];
			// Counters wrap and writes to them are dropped
			if (irq_taken)
				irq_cnt <= irq_cnt + 1'b1;
			if (uop_fire)
				uop_cnt <= uop_cnt + 1'b1;
		end
	end

	// Read mux, unmapped offsets read back as zero
	always_comb
	begin
		prdata = '0;
		case (paddr)
			REG_CTRL:    prdata[CTRL_IEN_BIT] = irq_enable;
			REG_VECTOR:  prdata[7:0] = irq_vector;
			REG_IRQ_CNT: prdata = irq_cnt;
			REG_UOP_CNT: prdata = uop_cnt;
			default:     prdata = '0;
		endcase
	end

endmodule

// ==== design/extract_sequencer.sv ====
// Extract sequencer
// Tracks pending interrupts and register list expansion, builds injected
// entries and drives the advance and squash controls of the output register

`timescale 1ns/1ps

`include "extract_defs.svh"

module extract_sequencer
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  in_valid,
	input  logic [31:0]           in_pc,
	input  logic [31:0]           in_ins,
	input  logic                  out_valid,
	input  logic                  out_ready,
	input  logic                  irq,
	input  logic                  flush,
	input  logic                  irq_enable,
	input  logic [7:0]            irq_vector,
	input  logic [`EXT_REG_W-1:0] cur_reg,
	input  logic                  last,
	input  logic                  empty,
	output logic                  in_ready,
	output logic                  en,
	output logic                  nop,
	output logic                  sel_inj,
	output ins_pkg::entry_t       inj_entry,
	output ins_pkg::entry_t       fetch_entry,
	output logic                  cnt_load,
	output logic                  cnt_step,
	output logic [`EXT_NREGS-1:0] cnt_mask,
	output logic                  irq_taken,
	output logic                  uop_fire
);

	import ins_pkg::*;
	import ctl_pkg::*;

	seq_state_e            state;
	seq_state_e            state_nxt;
	logic                  irq_q;
	logic                  irq_edge;
	logic                  pending;
	logic                  can_adv;
	logic                  accept;
	logic                  inject;
	logic                  emit;
	logic                  is_list;
	logic                  mask_nz;
	logic                  lost_irq;
	logic                  held_irq;
	logic                  held_uop;
	logic                  out_take;
	logic [`EXT_OPC_W-1:0] opc;
	logic [31:0]           list_pc;
	logic [`EXT_INS_W-1:0] list_ins;

	// ======================================================================
	// Handshake and decode
	// ======================================================================

	// The output register may load when it is empty or being drained
	assign can_adv = out_ready | ~out_valid;

	assign opc = in_ins[`EXT_OPC_W-1:0];
	assign is_list = (opc == OP_PUSHM) | (opc == OP_POPM);
	assign cnt_mask = in_ins[`EXT_MASK_LSB +: `EXT_NREGS];
	assign mask_nz = |cnt_mask;

	// Only one fetched instruction is ever owned by the stage
	assign in_ready = (state == SEQ_IDLE) & ~pending & ~flush & can_adv;
	assign accept = in_valid & in_ready;

	// The injected interrupt borrows the pc of the waiting fetch
	assign inject = (state == SEQ_IRQ) & in_valid & can_adv & ~flush;

	assign cnt_load = accept & is_list;
	assign cnt_step = (state == SEQ_LIST) & can_adv & ~flush & ~empty;

	assign irq_edge = irq & ~irq_q;

	// ======================================================================
	// State machine
	// ======================================================================

	always_comb
	begin
		state_nxt = state;
		emit = 1'b0;
		case (state)
			SEQ_IDLE:
			begin
				// List instructions themselves never reach decode
				if (accept)
				begin
					emit = ~is_list;
					if (is_list && mask_nz)
						state_nxt = SEQ_LIST;
				end
				else if (pending)
					state_nxt = SEQ_IRQ;
			end
			SEQ_IRQ:
			begin
				if (inject)
				begin
					emit = 1'b1;
					state_nxt = SEQ_IDLE;
				end
			end
			SEQ_LIST:
			begin
				if (empty)
					state_nxt = SEQ_IDLE;
				else if (cnt_step)
				begin
					emit = 1'b1;
					if (last)
						state_nxt = SEQ_IDLE;
				end
			end
			default:
				state_nxt = SEQ_IDLE;
		endcase
		// Flush beats everything and drops the rest of a list
		if (flush)
		begin
			state_nxt = SEQ_IDLE;
			emit = 1'b0;
		end
	end

	// During a flush the output slot is overwritten with a squashed entry
	assign en = can_adv | flush;
	assign nop = ~emit;
	assign sel_inj = (state != SEQ_IDLE);

	// An injected interrupt squashed before decode took it is raised again
	assign lost_irq = flush & out_valid & held_irq;

	// Events count at the decode handshake so squashed entries are left out
	assign out_take = out_valid & out_ready & ~flush;
	assign irq_taken = out_take & held_irq;
	assign uop_fire = out_take & held_uop;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= SEQ_IDLE;
			irq_q <= 1'b0;
			pending <= 1'b0;
			held_irq <= 1'b0;
			held_uop <= 1'b0;
		end
		else
		begin
			state <= state_nxt;
			irq_q <= irq;
			// A new edge during injection stays pending for the next round
			pending <= (pending & ~inject) | (irq_edge & irq_enable) | lost_irq;
			// Remember what kind of entry the output register holds
			if (en)
			begin
				held_irq <= emit & (state == SEQ_IRQ);
				held_uop <= emit & (state == SEQ_LIST);
			end
		end
	end

	// Copy of the list instruction for building its micro-ops
	always_ff @(posedge clk)
	begin
		if (cnt_load)
		begin
			list_pc <= in_pc;
			list_ins <= in_ins;
		end
	end

	// ======================================================================
	// Entry builders
	// ======================================================================

	always_comb
	begin
		fetch_entry = '0;
		fetch_entry.valid = 1'b1;
		fetch_entry.exc = FLT_NONE;
		fetch_entry.pc = in_pc;
		fetch_entry.ins = in_ins;
	end

	always_comb
	begin
		inj_entry = '0;
		inj_entry.valid = 1'b1;
		if (state == SEQ_IRQ)
		begin
			inj_entry.exc = FLT_IRQ;
			inj_entry.pc = in_pc;
			inj_entry.ins[`EXT_OPC_W-1:0] = OP_IRQ;
			inj_entry.ins[`EXT_VEC_LSB +: 8] = irq_vector;
		end
		else
		begin
			// Micro-op keeps the upper bits of the list word and swaps the opcode
			inj_entry.exc = FLT_NONE;
			inj_entry.pc = list_pc;
			inj_entry.ins = list_ins;
			inj_entry.ins[`EXT_OPC_W-1:0] =
				(list_ins[`EXT_OPC_W-1:0] == OP_POPM) ? OP_POP : OP_PUSH;
			inj_entry.uop_reg = cur_reg;
			inj_entry.micro = 1'b1;
		end
	end

endmodule

// ==== design/ins_extract_top.sv ====
// Instruction extract stage
// Sits between fetch and decode, expands register lists into micro-ops
// and injects interrupts, with an APB block for configuration and counts

`timescale 1ns/1ps

`include "extract_defs.svh"

module ins_extract_top
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  in_valid,
	output logic                  in_ready,
	input  logic [31:0]           in_pc,
	input  logic [`EXT_INS_W-1:0] in_ins,
	output logic                  out_valid,
	input  logic                  out_ready,
	output logic [31:0]           out_pc,
	output logic [`EXT_INS_W-1:0] out_ins,
	output logic [`EXT_REG_W-1:0] out_reg,
	output logic                  out_micro,
	output ins_pkg::fault_e       out_exc,
	input  logic                  irq,
	input  logic                  flush,
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  logic [3:0]            paddr,
	input  logic [31:0]           pwdata,
	output logic [31:0]           prdata,
	output logic                  pready,
	output logic                  pslverr
);

	import ins_pkg::*;

	logic                  en;
	logic                  nop;
	logic                  sel_inj;
	entry_t                inj_entry;
	entry_t                fetch_entry;
	entry_t                out_entry;
	logic                  cnt_load;
	logic                  cnt_step;
	logic [`EXT_NREGS-1:0] cnt_mask;
	logic [`EXT_REG_W-1:0] cur_reg;
	logic                  last;
	logic                  empty;
	logic                  irq_taken;
	logic                  uop_fire;
	logic                  irq_enable;
	logic [7:0]            irq_vector;

	extract_sequencer u_seq
	(
		.clk(clk), .reset(reset),
		.in_valid(in_valid), .in_pc(in_pc), .in_ins(in_ins),
		.out_valid(out_valid), .out_ready(out_ready),
		.irq(irq), .flush(flush),
		.irq_enable(irq_enable), .irq_vector(irq_vector),
		.cur_reg(cur_reg), .last(last), .empty(empty),
		.in_ready(in_ready), .en(en), .nop(nop), .sel_inj(sel_inj),
		.inj_entry(inj_entry), .fetch_entry(fetch_entry),
		.cnt_load(cnt_load), .cnt_step(cnt_step), .cnt_mask(cnt_mask),
		.irq_taken(irq_taken), .uop_fire(uop_fire)
	);

	reglist_counter u_cnt
	(
		.clk(clk), .reset(reset),
		.load(cnt_load), .step(cnt_step), .mask(cnt_mask),
		.cur_reg(cur_reg), .last(last), .empty(empty)
	);

	extract_mux u_mux
	(
		.clk(clk), .reset(reset),
		.en(en), .nop(nop), .sel_inj(sel_inj),
		.inj_entry(inj_entry), .fetch_entry(fetch_entry),
		.ins(out_entry)
	);

	extract_csr u_csr
	(
		.clk(clk), .reset(reset),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata),
		.irq_taken(irq_taken), .uop_fire(uop_fire),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.irq_enable(irq_enable), .irq_vector(irq_vector)
	);

	// Registered entry split out to the decode side
	assign out_valid = out_entry.valid;
	assign out_pc = out_entry.pc;
	assign out_ins = out_entry.ins;
	assign out_reg = out_entry.uop_reg;
	assign out_micro = out_entry.micro;
	assign out_exc = out_entry.exc;

endmodule

// ==== sim/tb_ins_extract.sv ====
// Instruction extract stage testbench
// Drives fetch, decode back-pressure, interrupts, flushes and APB accesses
// and checks every decode transfer against a reference expansion

`timescale 1ns/1ps

`include "extract_defs.svh"

module tb_ins_extract;

	import ins_pkg::*;
	import ctl_pkg::*;

	// ======================================================================
	// Run length
	// ======================================================================

	localparam int N_PLAIN = 40;
	localparam int N_LIST = 30;
	localparam int N_IRQ = 6;
	localparam int N_FLUSH = 4;
	// Every interrupt and flush round sends two instructions, plus two with irq disabled
	localparam int N_INS = N_PLAIN + N_LIST + 2 * N_IRQ + 2 + 2 * N_FLUSH;
	localparam int CYCLE_LIMIT = N_INS * 20 + 2000;

	logic                  clk;
	logic                  reset;
	logic                  in_valid;
	logic                  in_ready;
	logic [31:0]           in_pc;
	logic [`EXT_INS_W-1:0] in_ins;
	logic                  out_valid;
	logic                  out_ready;
	logic [31:0]           out_pc;
	logic [`EXT_INS_W-1:0] out_ins;
	logic [`EXT_REG_W-1:0] out_reg;
	logic                  out_micro;
	fault_e                out_exc;
	logic                  irq;
	logic                  flush;
	logic                  psel;
	logic                  penable;
	logic                  pwrite;
	logic [3:0]            paddr;
	logic [31:0]           pwdata;
	logic [31:0]           prdata;
	logic                  pready;
	logic                  pslverr;

	integer      seed;
	int          errors;
	int          checks;
	int          cycles;
	int          n_irq_taken;
	int          n_irq_seen;
	int          n_uop_taken;
	int          irqs_expected;
	int          n_exp;
	int          i;
	int          k;
	logic        ready_pat [0:255];
	logic [7:0]  ready_idx;
	logic        flush_req;
	logic        irq_owed;
	logic [7:0]  vec_cfg;
	logic [31:0] pc;
	logic [31:0] ins;
	logic [31:0] rd;
	logic        err;
	entry_t      exp_q [$];
	entry_t      exp_e;
	entry_t      cur;
	entry_t      held;
	logic        stalled;
	logic        after_flush;

	ins_extract_top i_dut
	(
		.clk(clk), .reset(reset),
		.in_valid(in_valid), .in_ready(in_ready), .in_pc(in_pc), .in_ins(in_ins),
		.out_valid(out_valid), .out_ready(out_ready), .out_pc(out_pc),
		.out_ins(out_ins), .out_reg(out_reg), .out_micro(out_micro),
		.out_exc(out_exc), .irq(irq), .flush(flush),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
	);

	initial
	begin
		clk = 1'b0;
	end

	always #2 clk = ~clk;

	// ======================================================================
	// Reference model
	// ======================================================================

	function automatic logic is_list_op(input logic [31:0] word);
		begin
			return (word[`EXT_OPC_W-1:0] == OP_PUSHM) || (word[`EXT_OPC_W-1:0] == OP_POPM);
		end
	endfunction

	// Number of decode entries one fetched word turns into
	function automatic int expand_count(input logic [31:0] word);
		int n;
		begin
			n = 0;
			if (!is_list_op(word))
				return 1;
			for (int r = 0; r < `EXT_NREGS; r++)
				if (word[`EXT_MASK_LSB + r])
					n++;
			return n;
		end
	endfunction

	// Entry number k of a fetched word, micro-ops go up from the lowest register
	function automatic entry_t expand_entry(input logic [31:0] epc, input logic [31:0] word,
		input int idx);
		entry_t e;
		int     seen;
		begin
			e = '0;
			seen = 0;
			e.valid = 1'b1;
			e.exc = FLT_NONE;
			e.pc = epc;
			e.ins = word;
			if (is_list_op(word))
			begin
				e.ins[`EXT_OPC_W-1:0] = (word[`EXT_OPC_W-1:0] == OP_POPM) ? OP_POP : OP_PUSH;
				e.micro = 1'b1;
				for (int r = 0; r < `EXT_NREGS; r++)
				begin
					if (word[`EXT_MASK_LSB + r])
					begin
						if (seen == idx)
							e.uop_reg = `EXT_REG_W'(r);
						seen++;
					end
				end
			end
			return e;
		end
	endfunction

	// Injected interrupt borrows the pc of the fetch it is placed ahead of
	function automatic entry_t irq_entry(input logic [31:0] epc, input logic [7:0] vec);
		entry_t e;
		begin
			e = '0;
			e.valid = 1'b1;
			e.exc = FLT_IRQ;
			e.pc = epc;
			e.ins[`EXT_OPC_W-1:0] = OP_IRQ;
			e.ins[`EXT_VEC_LSB +: 8] = vec;
			return e;
		end
	endfunction

	// ======================================================================
	// Checking
	// ======================================================================

	task check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
		begin
			checks++;
			if (got !== exp)
			begin
				errors++;
				$display("mismatch at %0t ns: %s, got 0x%0h expected 0x%0h",
					$time, what, got, exp);
			end
		end
	endtask

	task compare_entry(input string ctx, input entry_t got, input entry_t exp);
		begin
			check_value({ctx, " valid"}, got.valid, exp.valid);
			check_value({ctx, " pc"}, got.pc, exp.pc);
			check_value({ctx, " word"}, got.ins, exp.ins);
			check_value({ctx, " register"}, got.uop_reg, exp.uop_reg);
			check_value({ctx, " micro flag"}, got.micro, exp.micro);
			check_value({ctx, " fault"}, got.exc, exp.exc);
		end
	endtask

	// Sampled just before the rising edge, when every input has settled
	always
	begin
		@(negedge clk);
		#1;
		cur.valid = out_valid;
		cur.exc = out_exc;
		cur.pc = out_pc;
		cur.ins = out_ins;
		cur.uop_reg = out_reg;
		cur.micro = out_micro;
		if (!reset)
		begin
			if (after_flush)
			begin
				check_value("out_valid after flush", out_valid, 1'b0);
				after_flush = 1'b0;
			end
			if (flush)
			begin
				// Everything still owed by the stage is dropped
				exp_q.delete();
				after_flush = 1'b1;
				stalled = 1'b0;
			end
			else
			begin
				if (stalled)
					compare_entry("stalled output", cur, held);
				if (in_valid && in_ready)
				begin
					n_exp = expand_count(in_ins);
					for (int j = 0; j < n_exp; j++)
						exp_q.push_back(expand_entry(in_pc, in_ins, j));
				end
				if (out_valid && out_ready)
				begin
					// Interrupts seen at the decode side, whatever the model expects
					if (cur.exc == FLT_IRQ)
						n_irq_seen++;
					if (exp_q.size() == 0)
					begin
						errors++;
						$display("error at %0t ns: decode took an entry that was not expected",
							$time);
					end
					else
					begin
						exp_e = exp_q.pop_front();
						compare_entry("output", cur, exp_e);
						if (exp_e.exc == FLT_IRQ)
							n_irq_taken++;
						if (exp_e.micro)
							n_uop_taken++;
					end
				end
				stalled = out_valid && !out_ready;
				held = cur;
			end
		end
	end

	// ======================================================================
	// Decode side and flush drive
	// ======================================================================

	// Decode is held off during a flush so that the squashed slot is not taken
	always @(negedge clk)
	begin
		if (flush_req)
		begin
			flush = 1'b1;
			out_ready = 1'b0;
			flush_req = 1'b0;
		end
		else
		begin
			flush = 1'b0;
			out_ready = ready_pat[ready_idx];
		end
		ready_idx = ready_idx + 1'b1;
	end

	// ======================================================================
	// Stimulus tasks, all entered and left on a falling edge
	// ======================================================================

	task apb_write(input logic [3:0] addr, input logic [31:0] data, output logic perr);
		begin
			psel = 1'b1;
			penable = 1'b0;
			pwrite = 1'b1;
			paddr = addr;
			pwdata = data;
			@(negedge clk);
			penable = 1'b1;
			#1;
			perr = pslverr;
			check_value("pready on write", pready, 1'b1);
			@(negedge clk);
			psel = 1'b0;
			penable = 1'b0;
			pwrite = 1'b0;
		end
	endtask

	task apb_read(input logic [3:0] addr, output logic [31:0] data, output logic perr);
		begin
			psel = 1'b1;
			penable = 1'b0;
			pwrite = 1'b0;
			paddr = addr;
			@(negedge clk);
			penable = 1'b1;
			#1;
			data = prdata;
			perr = pslverr;
			check_value("pready on read", pready, 1'b1);
			@(negedge clk);
			psel = 1'b0;
			penable = 1'b0;
		end
	endtask

	// Holds the fetch valid until the stage takes the word
	task send_ins(input logic [31:0] fpc, input logic [31:0] word);
		logic taken;
		begin
			taken = 1'b0;
			if (irq_owed)
			begin
				exp_q.push_back(irq_entry(fpc, vec_cfg));
				irqs_expected++;
				irq_owed = 1'b0;
			end
			in_valid = 1'b1;
			in_pc = fpc;
			in_ins = word;
			while (!taken)
			begin
				#1;
				taken = in_ready;
				@(negedge clk);
			end
			in_valid = 1'b0;
		end
	endtask

	// One rising edge on irq while fetch is quiet
	task raise_irq(input logic enabled);
		begin
			irq = 1'b1;
			repeat (3) @(negedge clk);
			irq = 1'b0;
			@(negedge clk);
			irq_owed = enabled;
		end
	endtask

	task gen_plain(output logic [31:0] word);
		begin
			word = $random(seed);
			word[`EXT_OPC_W-1:0] = word[9] ? OP_ALU : OP_NOP;
		end
	endtask

	task gen_list(input logic zero_mask, output logic [31:0] word);
		begin
			word = $random(seed);
			word[`EXT_OPC_W-1:0] = word[7] ? OP_POPM : OP_PUSHM;
			// Thin some masks out so short lists get covered as well
			if (word[8])
				word[`EXT_MASK_LSB +: `EXT_NREGS] = word[`EXT_MASK_LSB +: `EXT_NREGS] & $random(seed);
			if (zero_mask)
				word[`EXT_MASK_LSB +: `EXT_NREGS] = '0;
		end
	endtask

	// ======================================================================
	// Test sequence
	// ======================================================================

	initial
	begin
		seed = 74584;
		errors = 0;
		checks = 0;
		n_irq_taken = 0;
		n_irq_seen = 0;
		n_uop_taken = 0;
		irqs_expected = 0;
		reset = 1'b1;
		in_valid = 1'b0;
		in_pc = '0;
		in_ins = '0;
		out_ready = 1'b0;
		irq = 1'b0;
		flush = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		flush_req = 1'b0;
		irq_owed = 1'b0;
		vec_cfg = 8'h00;
		ready_idx = '0;
		stalled = 1'b0;
		after_flush = 1'b0;
		pc = 32'h0000_1000;
		for (i = 0; i < 256; i++)
			ready_pat[i] = (($random(seed) & 7) < 5);

		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// Register block comes out of reset cleared
		check_value("out_valid after reset", out_valid, 1'b0);
		check_value("pslverr after reset", pslverr, 1'b0);
		apb_read(REG_CTRL, rd, err);
		check_value("control after reset", rd, 32'h0);
		apb_read(REG_VECTOR, rd, err);
		check_value("vector after reset", rd, 32'h0);
		apb_read(REG_IRQ_CNT, rd, err);
		check_value("irq count after reset", rd, 32'h0);
		apb_read(REG_UOP_CNT, rd, err);
		check_value("uop count after reset", rd, 32'h0);
		check_value("pslverr on mapped read", err, 1'b0);
		apb_read(4'h2, rd, err);
		check_value("pslverr on unmapped read", err, 1'b1);
		check_value("unmapped read data", rd, 32'h0);
		apb_write(4'h6, 32'hffff_ffff, err);
		check_value("pslverr on unmapped write", err, 1'b1);

		for (i = 0; i < N_PLAIN; i++)
		begin
			gen_plain(ins);
			send_ins(pc, ins);
			pc += 4;
		end

		// Every seventh list has an empty mask
		for (i = 0; i < N_LIST; i++)
		begin
			gen_list(i % 7 == 3, ins);
			send_ins(pc, ins);
			pc += 4;
		end

		// An edge with the enable clear must not inject anything
		raise_irq(1'b0);
		gen_plain(ins);
		send_ins(pc, ins);
		pc += 4;
		gen_list(1'b0, ins);
		send_ins(pc, ins);
		pc += 4;

		vec_cfg = 8'ha5;
		apb_write(REG_CTRL, 32'h1, err);
		apb_write(REG_VECTOR, {24'h0, vec_cfg}, err);
		apb_read(REG_CTRL, rd, err);
		check_value("control read back", rd, 32'h1);
		apb_read(REG_VECTOR, rd, err);
		check_value("vector read back", rd, {24'h0, vec_cfg});

		for (i = 0; i < N_IRQ; i++)
		begin
			raise_irq(1'b1);
			gen_plain(ins);
			send_ins(pc, ins);
			pc += 4;
			gen_list(1'b0, ins);
			send_ins(pc, ins);
			pc += 4;
		end

		// Flush a full list a few micro-ops in, then carry on with plain work
		for (i = 0; i < N_FLUSH; i++)
		begin
			gen_list(1'b0, ins);
			ins[`EXT_MASK_LSB +: `EXT_NREGS] = '1;
			send_ins(pc, ins);
			pc += 4;
			k = $random(seed) & 3;
			repeat (k) @(negedge clk);
			@(posedge clk);
			flush_req = 1'b1;
			@(negedge clk);
			@(negedge clk);
			gen_plain(ins);
			send_ins(pc, ins);
			pc += 4;
		end

		while (exp_q.size() != 0)
			@(negedge clk);
		repeat (4) @(negedge clk);

		check_value("injected interrupts", n_irq_seen, irqs_expected);
		apb_read(REG_IRQ_CNT, rd, err);
		check_value("irq count register", rd, n_irq_taken);
		apb_read(REG_UOP_CNT, rd, err);
		check_value("uop count register", rd, n_uop_taken);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	// Run limit scales with the number of instructions sent
	initial
	begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT)
		begin
			@(posedge clk);
			cycles++;
		end
		errors++;
		$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("checks %0d, errors %0d", checks, errors);
		$display("Checks failed");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+common
common/ins_pkg.sv
common/ctl_pkg.sv
design/extract_mux.sv
design/reglist_counter.sv
design/extract_csr.sv
design/extract_sequencer.sv
design/ins_extract_top.sv
sim/tb_ins_extract.sv
